// ==== design/uart_bridge_pkg.sv ====
package uart_bridge_pkg;

  typedef logic [7:0]  byte_t;        // serial data, commands, ports, registers
  typedef logic [15:0] word_t;        // one word of the store
  typedef logic [7:0]  store_addr_t;

  // serial bit timing
  localparam int CLKS_PER_BIT = 16;
  localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
  localparam logic [CLK_CNT_W-1:0] BIT_CNT_LAST = CLK_CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CLK_CNT_W-1:0] BIT_CNT_HALF = CLK_CNT_W'(CLKS_PER_BIT / 2);

  // word store
  localparam int STORE_DEPTH   = 256;
  localparam int STORE_LATENCY = 3;   // cycles from req seen to ack
  localparam int LAT_CNT_W     = $clog2(STORE_LATENCY + 1);
  localparam logic [LAT_CNT_W-1:0] LAT_CNT_LAST = LAT_CNT_W'(STORE_LATENCY - 1);

  // base codes carry the group in the high nibble
  localparam byte_t CMD_CLK_SET   = 8'h10;
  localparam byte_t CMD_CLK_CLR   = 8'h11;
  localparam byte_t CMD_RST_SET   = 8'h12;
  localparam byte_t CMD_RST_CLR   = 8'h13;
  localparam byte_t CMD_IN_BASE   = 8'h20;
  localparam byte_t CMD_OUT_BASE  = 8'h30;
  localparam byte_t CMD_WREG_BASE = 8'h40;
  localparam byte_t CMD_RREG_BASE = 8'h50;
  localparam byte_t CMD_STORE_WR  = 8'hA0;
  localparam byte_t CMD_STORE_RD  = 8'hA1;

  typedef enum logic [2:0] {
    idle,
    exec,       // decode and act on the latched command
    wait_data,  // waiting for the command's data byte
    wait_ack,   // store request outstanding
    reply,      // reply byte waits for the transmitter
    done
  } engine_state_t;

endpackage

// ==== design/uart_rx.sv ====
module uart_rx (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  logic                   uart_rxd,
  output logic                   rx_valid,
  output uart_bridge_pkg::byte_t rx_data
);

  logic rxd_meta;
  logic rxd_sync;
  logic rxd_prev;   // for start edge detect
  logic active;
  logic [uart_bridge_pkg::CLK_CNT_W-1:0] clk_cnt;
  logic [3:0] bit_idx;  // 0 start, 1..8 data, 9 stop
  uart_bridge_pkg::byte_t shift;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
      active   <= 1'b0;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      shift    <= '0;
      rx_valid <= 1'b0;
      rx_data  <= '0;
    end else begin
      rxd_meta <= uart_rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
      rx_valid <= 1'b0;
      if (!active) begin
        if (rxd_prev && !rxd_sync) begin
          // half a bit preloaded so every sample lands mid-bit
          active  <= 1'b1;
          clk_cnt <= uart_bridge_pkg::BIT_CNT_HALF;
          bit_idx <= '0;
        end
      end else if (clk_cnt == uart_bridge_pkg::BIT_CNT_LAST) begin
        clk_cnt <= '0;
        if (bit_idx == 4'd0) begin
          if (rxd_sync) active <= 1'b0;  // glitch, not a start bit
          else bit_idx <= 4'd1;
        end else if (bit_idx == 4'd9) begin
          active <= 1'b0;
          if (rxd_sync) begin   // framing ok
            rx_valid <= 1'b1;
            rx_data  <= shift;
          end
        end else begin
          shift   <= {rxd_sync, shift[7:1]};  // lsb arrives first
          bit_idx <= bit_idx + 4'd1;
        end
      end else begin
        clk_cnt <= clk_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== design/uart_tx.sv ====
module uart_tx (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  logic                   tx_start,
  input  uart_bridge_pkg::byte_t tx_data,
  output logic                   uart_txd,
  output logic                   tx_busy
);

  logic [9:0] frame;  // stop, data, start; bit 0 is on the line
  logic [uart_bridge_pkg::CLK_CNT_W-1:0] clk_cnt;
  logic [3:0] bit_cnt;

  assign uart_txd = frame[0];

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      frame   <= '1;    // line idles high
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx_busy <= 1'b0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        frame   <= {1'b1, tx_data, 1'b0};
        clk_cnt <= '0;
        bit_cnt <= '0;
        tx_busy <= 1'b1;
      end
    end else if (clk_cnt == uart_bridge_pkg::BIT_CNT_LAST) begin
      clk_cnt <= '0;
      frame   <= {1'b1, frame[9:1]};  // back-fill with idle level
      if (bit_cnt == 4'd9) begin
        // end of stop bit
        tx_busy <= 1'b0;
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

// ==== design/word_store.sv ====
module word_store (
  input  logic                         sys_clk,
  input  logic                         sys_rst_n,
  input  logic                         store_req,
  input  logic                         store_we,
  input  uart_bridge_pkg::store_addr_t store_addr,
  input  uart_bridge_pkg::word_t       store_wdata,
  output logic                         store_ack,
  output uart_bridge_pkg::word_t       store_rdata
);

  uart_bridge_pkg::word_t mem [uart_bridge_pkg::STORE_DEPTH];

  logic active;
  logic [uart_bridge_pkg::LAT_CNT_W-1:0] lat_cnt;
  logic last;

  assign last = active && (lat_cnt == uart_bridge_pkg::LAT_CNT_LAST);

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      active    <= 1'b0;
      lat_cnt   <= '0;
      store_ack <= 1'b0;
    end else begin
      store_ack <= last;
      if (last) begin
        active <= 1'b0;
      end else if (active) begin
        lat_cnt <= lat_cnt + 1'b1;
      end else if (store_req && !store_ack) begin
        // requester still holds req during its ack cycle
        active  <= 1'b1;
        lat_cnt <= 1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (last) begin
      if (store_we) mem[store_addr] <= store_wdata;
      else store_rdata <= mem[store_addr];
    end
  end

endmodule

// ==== design/uart_mcu.sv ====
module uart_mcu (
  input  logic                         sys_clk,
  input  logic                         sys_rst_n,
  input  logic                         rx_valid,
  input  uart_bridge_pkg::byte_t       rx_data,
  input  logic                         tx_busy,
  output logic                         tx_start,
  output uart_bridge_pkg::byte_t       tx_data,
  output logic                         store_req,
  output logic                         store_we,
  output uart_bridge_pkg::store_addr_t store_addr,
  output uart_bridge_pkg::word_t       store_wdata,
  input  logic                         store_ack,
  input  uart_bridge_pkg::word_t       store_rdata,
  output logic                         busy,
  output logic                         out_clk,
  output logic                         out_rst,
  input  uart_bridge_pkg::byte_t       in_pin0,
  input  uart_bridge_pkg::byte_t       in_pin1,
  input  uart_bridge_pkg::byte_t       in_pin2,
  input  uart_bridge_pkg::byte_t       in_pin3,
  output uart_bridge_pkg::byte_t       out_pin0,
  output uart_bridge_pkg::byte_t       out_pin1,
  output uart_bridge_pkg::byte_t       out_pin2,
  output uart_bridge_pkg::byte_t       out_pin3
);

  uart_bridge_pkg::engine_state_t state;
  uart_bridge_pkg::byte_t cmd;
  uart_bridge_pkg::byte_t data_byte;
  logic have_data;                      // data byte for cmd is latched
  uart_bridge_pkg::byte_t req_cnt;      // cycles with req high
  uart_bridge_pkg::byte_t out_reg [4];
  uart_bridge_pkg::byte_t wreg [8];
  uart_bridge_pkg::byte_t rreg [8];     // only 0, 1 and 7 are ever loaded
  uart_bridge_pkg::byte_t in_sel;
  logic [3:0] grp;
  logic [3:0] idx;

  assign grp = cmd[7:4];
  assign idx = cmd[3:0];

  // done already counts as finished
  assign busy = (state != uart_bridge_pkg::idle) && (state != uart_bridge_pkg::done);
  assign tx_start = (state == uart_bridge_pkg::reply) && !tx_busy;

  assign out_pin0 = out_reg[0];
  assign out_pin1 = out_reg[1];
  assign out_pin2 = out_reg[2];
  assign out_pin3 = out_reg[3];

  always_comb begin
    unique case (idx[1:0])
      2'd0: in_sel = in_pin0;
      2'd1: in_sel = in_pin1;
      2'd2: in_sel = in_pin2;
      default: in_sel = in_pin3;
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= uart_bridge_pkg::idle;
      cmd         <= '0;
      data_byte   <= '0;
      have_data   <= 1'b0;
      req_cnt     <= '0;
      tx_data     <= '0;
      store_req   <= 1'b0;
      store_we    <= 1'b0;
      store_addr  <= '0;
      store_wdata <= '0;
      out_clk     <= 1'b0;
      out_rst     <= 1'b0;
      for (int i = 0; i < 4; i++) out_reg[i] <= '0;
      for (int i = 0; i < 8; i++) begin
        wreg[i] <= '0;
        rreg[i] <= '0;
      end
    end else begin
      unique case (state)
        uart_bridge_pkg::idle, uart_bridge_pkg::done: begin
          state <= uart_bridge_pkg::idle;
          if (rx_valid) begin
            cmd       <= rx_data;
            have_data <= 1'b0;
            state     <= uart_bridge_pkg::exec;
          end
        end
        uart_bridge_pkg::exec: begin
          state <= uart_bridge_pkg::done;   // unless a branch below waits
          if (cmd == uart_bridge_pkg::CMD_CLK_SET) out_clk <= 1'b1;
          else if (cmd == uart_bridge_pkg::CMD_CLK_CLR) out_clk <= 1'b0;
          else if (cmd == uart_bridge_pkg::CMD_RST_SET) out_rst <= 1'b1;
          else if (cmd == uart_bridge_pkg::CMD_RST_CLR) out_rst <= 1'b0;
          else if (grp == uart_bridge_pkg::CMD_IN_BASE[7:4] && idx < 4'd4) begin
            tx_data <= in_sel;
            state   <= uart_bridge_pkg::reply;
          end else if (grp == uart_bridge_pkg::CMD_OUT_BASE[7:4] && idx < 4'd4) begin
            if (have_data) out_reg[idx[1:0]] <= data_byte;
            else state <= uart_bridge_pkg::wait_data;
          end else if (grp == uart_bridge_pkg::CMD_WREG_BASE[7:4] && idx < 4'd8) begin
            if (have_data) wreg[idx[2:0]] <= data_byte;
            else state <= uart_bridge_pkg::wait_data;
          end else if (grp == uart_bridge_pkg::CMD_RREG_BASE[7:4] && idx < 4'd8) begin
            tx_data <= rreg[idx[2:0]];
            state   <= uart_bridge_pkg::reply;
          end else if (cmd == uart_bridge_pkg::CMD_STORE_WR ||
                       cmd == uart_bridge_pkg::CMD_STORE_RD) begin
            store_req   <= 1'b1;
            store_we    <= (cmd == uart_bridge_pkg::CMD_STORE_WR);
            store_addr  <= wreg[2];
            store_wdata <= {wreg[1], wreg[0]};
            req_cnt     <= '0;
            state       <= uart_bridge_pkg::wait_ack;
          end
        end
        uart_bridge_pkg::wait_data: begin
          if (rx_valid) begin
            data_byte <= rx_data;
            have_data <= 1'b1;
            state     <= uart_bridge_pkg::exec;   // back to finish the write
          end
        end
        uart_bridge_pkg::wait_ack: begin
          if (store_ack) begin
            store_req <= 1'b0;
            rreg[7]   <= req_cnt;
            if (!store_we) begin
              rreg[0] <= store_rdata[7:0];
              rreg[1] <= store_rdata[15:8];
            end
            state <= uart_bridge_pkg::done;
          end else begin
            req_cnt <= req_cnt + 8'd1;
          end
        end
        default: begin
          // tx_start goes out in the reply state once the line is free
          if (!tx_busy) state <= uart_bridge_pkg::done;
        end
      endcase
    end
  end

endmodule

// ==== design/uart_bridge_top.sv ====
module uart_bridge_top (
  input  logic                   sys_clk,
  input  logic                   sys_rst_n,
  input  logic                   uart_rxd,
  output logic                   uart_txd,
  output logic                   busy,
  output logic                   out_clk,
  output logic                   out_rst,
  input  uart_bridge_pkg::byte_t in_pin0,
  input  uart_bridge_pkg::byte_t in_pin1,
  input  uart_bridge_pkg::byte_t in_pin2,
  input  uart_bridge_pkg::byte_t in_pin3,
  output uart_bridge_pkg::byte_t out_pin0,
  output uart_bridge_pkg::byte_t out_pin1,
  output uart_bridge_pkg::byte_t out_pin2,
  output uart_bridge_pkg::byte_t out_pin3
);

  // receiver to engine
  logic                   rx_valid;
  uart_bridge_pkg::byte_t rx_data;

  // engine to transmitter
  logic                   tx_start;
  logic                   tx_busy;
  uart_bridge_pkg::byte_t tx_data;

  // engine to word store
  logic                         store_req;
  logic                         store_we;
  logic                         store_ack;
  uart_bridge_pkg::store_addr_t store_addr;
  uart_bridge_pkg::word_t       store_wdata;
  uart_bridge_pkg::word_t       store_rdata;

  uart_rx uart_rx_inst (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_rxd  (uart_rxd),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data)
  );

  uart_mcu uart_mcu_inst (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .tx_busy     (tx_busy),
    .tx_start    (tx_start),
    .tx_data     (tx_data),
    .store_req   (store_req),
    .store_we    (store_we),
    .store_addr  (store_addr),
    .store_wdata (store_wdata),
    .store_ack   (store_ack),
    .store_rdata (store_rdata),
    .busy        (busy),
    .out_clk     (out_clk),
    .out_rst     (out_rst),
    .in_pin0     (in_pin0),
    .in_pin1     (in_pin1),
    .in_pin2     (in_pin2),
    .in_pin3     (in_pin3),
    .out_pin0    (out_pin0),
    .out_pin1    (out_pin1),
    .out_pin2    (out_pin2),
    .out_pin3    (out_pin3)
  );

  word_store word_store_inst (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .store_req   (store_req),
    .store_we    (store_we),
    .store_addr  (store_addr),
    .store_wdata (store_wdata),
    .store_ack   (store_ack),
    .store_rdata (store_rdata)
  );

  uart_tx uart_tx_inst (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .uart_txd  (uart_txd),
    .tx_busy   (tx_busy)
  );

endmodule

// ==== sim/uart_bridge_properties.sv ====
module uart_bridge_properties (
  input logic                           sys_clk,
  input logic                           sys_rst_n,
  input uart_bridge_pkg::engine_state_t state,
  input logic                           busy,
  input logic                           store_req,
  input logic                           store_ack,
  input logic                           tx_start,
  input logic                           tx_busy
);
  timeunit 1ns;
  timeprecision 1ps;

  int assert_fail_count = 0;

  // no request may be left outstanding once the engine is back in idle
  idle_not_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    state == uart_bridge_pkg::idle |-> !busy && !store_req)
    else begin
      assert_fail_count++;
      $error("busy or store_req is high while the engine is idle");
    end

  // level request held until the store answers
  req_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    store_req && !store_ack |=> store_req)
    else begin
      assert_fail_count++;
      $error("store_req dropped before store_ack");
    end

  // transmitter must be free and take the byte the next cycle
  start_when_free: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    tx_start |=> tx_busy && !$past(tx_busy))
    else begin
      assert_fail_count++;
      $error("tx_start was not taken by an idle transmitter");
    end

  start_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    tx_start |=> !tx_start)
    else begin
      assert_fail_count++;
      $error("tx_start held longer than one cycle");
    end

  ack_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    store_ack |=> !store_ack)
    else begin
      assert_fail_count++;
      $error("store_ack held longer than one cycle");
    end

endmodule

bind uart_mcu uart_bridge_properties uart_bridge_properties_inst (
  .sys_clk   (sys_clk),
  .sys_rst_n (sys_rst_n),
  .state     (state),
  .busy      (busy),
  .store_req (store_req),
  .store_ack (store_ack),
  .tx_start  (tx_start),
  .tx_busy   (tx_busy)
);

// ==== sim/uart_bridge_tb.sv ====
module uart_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RX_TIMEOUT   = 400;  // longer than one command frame
  localparam int IDLE_TIMEOUT = 100;
  localparam int BIT_CLKS     = uart_bridge_pkg::CLKS_PER_BIT;

  logic sys_clk;
  logic sys_rst_n;
  logic uart_rxd;
  logic uart_txd;
  logic busy;
  logic out_clk;
  logic out_rst;
  uart_bridge_pkg::byte_t in_pin0;
  uart_bridge_pkg::byte_t in_pin1;
  uart_bridge_pkg::byte_t in_pin2;
  uart_bridge_pkg::byte_t in_pin3;
  uart_bridge_pkg::byte_t out_pin0;
  uart_bridge_pkg::byte_t out_pin1;
  uart_bridge_pkg::byte_t out_pin2;
  uart_bridge_pkg::byte_t out_pin3;

  uart_bridge_pkg::byte_t pin_value [4];   // driven onto in_pin0..3
  uart_bridge_pkg::byte_t out_expect [4];
  logic [31:0] lfsr = 32'hade9;
  int mismatch_errors = 0;
  int other_errors = 0;
  int prop_failures;

  uart_bridge_top uart_bridge_top_inst (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_rxd  (uart_rxd),
    .uart_txd  (uart_txd),
    .busy      (busy),
    .out_clk   (out_clk),
    .out_rst   (out_rst),
    .in_pin0   (in_pin0),
    .in_pin1   (in_pin1),
    .in_pin2   (in_pin2),
    .in_pin3   (in_pin3),
    .out_pin0  (out_pin0),
    .out_pin1  (out_pin1),
    .out_pin2  (out_pin2),
    .out_pin3  (out_pin3)
  );

  initial begin
    sys_clk = 1'b0;
    forever #50 sys_clk = ~sys_clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic uart_bridge_pkg::byte_t rand_byte();
    uart_bridge_pkg::byte_t value;
    for (int i = 0; i < 8; i++) value[i] = lfsr_bit();
    return value;
  endfunction

  function automatic uart_bridge_pkg::byte_t out_pin_at(input int n);
    case (n)
      0: return out_pin0;
      1: return out_pin1;
      2: return out_pin2;
      default: return out_pin3;
    endcase
  endfunction

  task automatic check_value(input string name, input uart_bridge_pkg::byte_t got,
                             input uart_bridge_pkg::byte_t exp);
    assert (got === exp) else begin
      mismatch_errors++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic send_byte(input uart_bridge_pkg::byte_t value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};  // stop, data lsb first, start
    for (int i = 0; i < 10; i++) begin
      @(negedge sys_clk);
      uart_rxd = frame[i];
      repeat (BIT_CLKS - 1) @(negedge sys_clk);
    end
  endtask

  task automatic recv_byte(output uart_bridge_pkg::byte_t value);
    int waited;
    uart_bridge_pkg::byte_t bits;
    waited = 0;
    bits = '0;
    value = '0;
    while (uart_txd === 1'b1 && waited < RX_TIMEOUT) begin
      @(negedge sys_clk);
      waited++;
    end
    if (uart_txd !== 1'b0) begin
      other_errors++;
      $display("timed out at %0t waiting for a reply start bit", $time);
    end else begin
      repeat (BIT_CLKS / 2) @(negedge sys_clk);  // middle of start bit
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge sys_clk);
        bits[i] = uart_txd;
      end
      repeat (BIT_CLKS) @(negedge sys_clk);
      assert (uart_txd === 1'b1) else begin
        other_errors++;
        $display("reply at %0t has no stop bit", $time);
      end
      value = bits;
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (busy !== 1'b0 && waited < IDLE_TIMEOUT) begin
      @(negedge sys_clk);
      waited++;
    end
    if (busy !== 1'b0) begin
      other_errors++;
      $display("busy still high at %0t after %0d cycles", $time, IDLE_TIMEOUT);
    end
  endtask

  task automatic expect_no_reply(input int cycles);
    int lows;
    lows = 0;
    for (int i = 0; i < cycles; i++) begin
      @(negedge sys_clk);
      if (uart_txd !== 1'b1) lows++;
    end
    assert (lows == 0) else begin
      other_errors++;
      $display("uart_txd went low at %0t although no reply was due", $time);
    end
  endtask

  task automatic send_cmd(input uart_bridge_pkg::byte_t cmd);
    send_byte(cmd);
    wait_idle();
  endtask

  task automatic send_cmd_data(input uart_bridge_pkg::byte_t cmd,
                               input uart_bridge_pkg::byte_t data);
    send_byte(cmd);
    send_byte(data);
    wait_idle();
  endtask

  // reply starts before the command frame ends, so listen alongside
  task automatic query(input uart_bridge_pkg::byte_t cmd, input uart_bridge_pkg::byte_t exp,
                       input string name);
    uart_bridge_pkg::byte_t reply;
    reply = '0;
    fork
      send_byte(cmd);
      recv_byte(reply);
    join
    wait_idle();
    check_value(name, reply, exp);
  endtask

  task automatic drive_in_pins();
    @(negedge sys_clk);
    in_pin0 = pin_value[0];
    in_pin1 = pin_value[1];
    in_pin2 = pin_value[2];
    in_pin3 = pin_value[3];
  endtask

  task automatic check_out_pins();
    for (int i = 0; i < 4; i++)
      check_value($sformatf("out_pin%0d", i), out_pin_at(i), out_expect[i]);
  endtask

  task automatic test_reset_state();
    check_value("uart_txd", 8'(uart_txd), 8'h01);
    check_value("busy", 8'(busy), 8'h00);
    check_value("out_clk", 8'(out_clk), 8'h00);
    check_value("out_rst", 8'(out_rst), 8'h00);
    for (int i = 0; i < 4; i++) out_expect[i] = '0;
    check_out_pins();
  endtask

  task automatic test_control_lines();
    send_cmd(uart_bridge_pkg::CMD_CLK_SET);
    check_value("out_clk", 8'(out_clk), 8'h01);
    check_value("out_rst", 8'(out_rst), 8'h00);
    send_cmd(uart_bridge_pkg::CMD_RST_SET);
    check_value("out_clk", 8'(out_clk), 8'h01);
    check_value("out_rst", 8'(out_rst), 8'h01);
    send_cmd(uart_bridge_pkg::CMD_CLK_CLR);
    check_value("out_clk", 8'(out_clk), 8'h00);
    check_value("out_rst", 8'(out_rst), 8'h01);
    send_cmd(uart_bridge_pkg::CMD_RST_CLR);
    check_value("out_clk", 8'(out_clk), 8'h00);
    check_value("out_rst", 8'(out_rst), 8'h00);
  endtask

  task automatic test_input_ports();
    for (int n = 0; n < 4; n++) pin_value[n] = rand_byte();
    drive_in_pins();
    for (int n = 0; n < 4; n++)
      query(uart_bridge_pkg::CMD_IN_BASE | uart_bridge_pkg::byte_t'(n), pin_value[n],
            $sformatf("reply to 2%0d", n));
  endtask

  task automatic test_output_ports();
    uart_bridge_pkg::byte_t data;
    for (int n = 0; n < 4; n++) begin
      data = rand_byte();
      send_cmd_data(uart_bridge_pkg::CMD_OUT_BASE | uart_bridge_pkg::byte_t'(n), data);
      out_expect[n] = data;
      check_out_pins();  // the other ports hold
    end
  endtask

  task automatic test_word_store();
    uart_bridge_pkg::byte_t lo;
    uart_bridge_pkg::byte_t hi;
    uart_bridge_pkg::byte_t addr;
    lo = rand_byte();
    hi = rand_byte();
    addr = rand_byte();
    send_cmd_data(uart_bridge_pkg::CMD_WREG_BASE, lo);
    send_cmd_data(uart_bridge_pkg::CMD_WREG_BASE | 8'h01, hi);
    send_cmd_data(uart_bridge_pkg::CMD_WREG_BASE | 8'h02, addr);
    send_cmd(uart_bridge_pkg::CMD_STORE_WR);
    // overwrite the data registers so the read must come from the store
    send_cmd_data(uart_bridge_pkg::CMD_WREG_BASE, ~lo);
    send_cmd_data(uart_bridge_pkg::CMD_WREG_BASE | 8'h01, ~hi);
    send_cmd(uart_bridge_pkg::CMD_STORE_RD);
    query(uart_bridge_pkg::CMD_RREG_BASE, lo, "read register 0");
    query(uart_bridge_pkg::CMD_RREG_BASE | 8'h01, hi, "read register 1");
    query(uart_bridge_pkg::CMD_RREG_BASE | 8'h07,
          uart_bridge_pkg::byte_t'(uart_bridge_pkg::STORE_LATENCY), "read register 7");
  endtask

  task automatic test_undefined_cmd();
    fork
      send_byte(8'h77);
      expect_no_reply(14 * BIT_CLKS);
    join
    wait_idle();
    query(uart_bridge_pkg::CMD_IN_BASE | 8'h02, pin_value[2], "reply to 22");
  endtask

  initial begin
    sys_rst_n = 1'b0;
    uart_rxd = 1'b1;  // line idle
    in_pin0 = '0;
    in_pin1 = '0;
    in_pin2 = '0;
    in_pin3 = '0;
    for (int i = 0; i < 4; i++) pin_value[i] = '0;
    repeat (8) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst_n = 1'b1;
    @(negedge sys_clk);

    test_reset_state();
    test_control_lines();
    test_input_ports();
    test_output_ports();
    test_word_store();
    test_undefined_cmd();

    prop_failures =
      uart_bridge_top_inst.uart_mcu_inst.uart_bridge_properties_inst.assert_fail_count;
    $display("errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatch_errors, other_errors, prop_failures);
    if (mismatch_errors + other_errors + prop_failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
design/uart_bridge_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/word_store.sv
design/uart_mcu.sv
design/uart_bridge_top.sv
sim/uart_bridge_properties.sv
sim/uart_bridge_tb.sv

// ==== Makefile ====
TOP := uart_bridge_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
